// File: hdl/router_pkg.sv
package router_pkg;

   //////////////////////////////
   // Port numbering
   //////////////////////////////
   localparam int num_ports  = 5;
   localparam int port_local = 0;
   localparam int port_north = 1;
   localparam int port_east  = 2;
   localparam int port_south = 3;
   localparam int port_west  = 4;

   //////////////////////////////
   // Flit format
   //////////////////////////////
   localparam int flit_width  = 16;
   localparam int coord_width = 3;

   // Single is a head flit that also closes the packet
   typedef enum logic [1:0] {
      kind_head   = 2'b00,
      kind_body   = 2'b01,
      kind_tail   = 2'b10,
      kind_single = 2'b11
   } flit_kind_t;

   // Kind lives in the top two bits of both views
   typedef union packed {
      struct packed {
         flit_kind_t                          kind;
         logic [coord_width-1:0]              dest_x;
         logic [coord_width-1:0]              dest_y;
         logic [flit_width-3-2*coord_width:0] payload;
      } hd;
      struct packed {
         flit_kind_t            kind;
         logic [flit_width-3:0] data;
      } bd;
   } flit_t;

endpackage

// File: hdl/input_buffer.sv
`timescale 1ns/1ps

module input_buffer import router_pkg::*;
#(
   parameter int fifo_depth = 4
)
(
   input  logic  clk,
   input  logic  rst,
   input  logic  wr_en,
   input  flit_t wr_flit,
   input  logic  pop,
   output flit_t head,
   output logic  empty,
   output logic  full
);

   localparam int ptr_width   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int count_width = $clog2(fifo_depth + 1);

   flit_t                  mem [fifo_depth];
   logic [ptr_width-1:0]   rd_ptr;
   logic [ptr_width-1:0]   wr_ptr;
   logic [count_width-1:0] count;
   logic                   do_write;
   logic                   do_read;

   // Wraps at fifo_depth, which need not be a power of two
   function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
      if (ptr == ptr_width'(fifo_depth - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign do_write = wr_en && !full;
   assign do_read  = pop && !empty;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_read)
            rd_ptr <= next_ptr(rd_ptr);
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_ptr] <= wr_flit;
   end

   // Show-ahead, the oldest flit is visible before its pop
   assign head  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == count_width'(fifo_depth));

   a_no_write_full: assert property (@(posedge clk) disable iff (rst) full |-> !wr_en);
   a_no_pop_empty:  assert property (@(posedge clk) disable iff (rst) empty |-> !pop);

endmodule

// File: hdl/route_compute.sv
`timescale 1ns/1ps

module route_compute import router_pkg::*;
#(
   parameter int unsigned router_x = 0,
   parameter int unsigned router_y = 0
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  flit_t                head,
   input  logic                 empty,
   input  logic                 pop,
   output logic [num_ports-1:0] req
);

   logic                 active_q;
   logic [num_ports-1:0] route_q;
   logic [num_ports-1:0] route_new;
   logic                 pkt_start;
   logic                 pkt_end;

   // XY order, resolve x first, then y
   always_comb
   begin
      route_new = '0;
      if (head.hd.dest_x > coord_width'(router_x))
         route_new[port_east] = 1'b1;
      else if (head.hd.dest_x < coord_width'(router_x))
         route_new[port_west] = 1'b1;
      else if (head.hd.dest_y > coord_width'(router_y))
         route_new[port_north] = 1'b1;
      else if (head.hd.dest_y < coord_width'(router_y))
         route_new[port_south] = 1'b1;
      else
         route_new[port_local] = 1'b1;
   end

   assign pkt_start = !empty && !active_q &&
                      (head.hd.kind == kind_head || head.hd.kind == kind_single);
   assign pkt_end   = pop && (head.bd.kind == kind_tail || head.bd.kind == kind_single);

   always_ff @(posedge clk)
   begin
      if (rst)
         active_q <= 1'b0;
      else if (pkt_end)
         active_q <= 1'b0;
      else if (pkt_start)
         active_q <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (pkt_start)
         route_q <= route_new;
   end

   // First cycle comes straight from the head decode
   assign req = active_q ? route_q : (pkt_start ? route_new : '0);

   a_req_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(req));

endmodule

// File: hdl/output_arbiter.sv
`timescale 1ns/1ps

module output_arbiter import router_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [num_ports-1:0] req,
   output logic [num_ports-1:0] gnt
);

   // One-hot grant states, all zero means idle
   localparam logic [num_ports-1:0] state_idle = '0;

   logic [num_ports-1:0] state_q;
   logic [num_ports-1:0] state_d;

   //////////////////////////////
   // State register
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst)
         state_q <= state_idle;
      else
         state_q <= state_d;
   end

   //////////////////////////////
   // Next state
   //////////////////////////////
   always_comb
   begin
      state_d = state_idle;
      if (state_q == state_idle)
      begin
         // Scan downward so the lowest requester is written last
         for (int i = num_ports - 1; i >= 0; i--)
         begin
            if (req[i])
               state_d = num_ports'(1) << i;
         end
      end
      else if ((state_q & req) != '0)
      begin
         // Sticky while the owner keeps asking
         state_d = state_q;
      end
   end

   assign gnt = state_q;

   a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

endmodule

// File: hdl/router_ctrl.sv
`timescale 1ns/1ps

module router_ctrl import router_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [num_ports-1:0] req_matrix [num_ports],
   input  logic [num_ports-1:0] empty,
   output logic [num_ports-1:0] gnt_matrix [num_ports],
   output logic [num_ports-1:0] pop
);

   logic [num_ports-1:0] served;
   logic [num_ports-1:0] gnt_col [num_ports];

   // One arbiter per output, row o of both matrices
   for (genvar o = 0; o < num_ports; o++)
   begin : g_arb
      output_arbiter u_output_arbiter (
         .clk (clk),
         .rst (rst),
         .req (req_matrix[o]),
         .gnt (gnt_matrix[o])
      );
   end

   // Grant lingers one cycle after a tail pop, so the request qualifies it
   always_comb
   begin
      served = '0;
      for (int i = 0; i < num_ports; i++)
      begin
         for (int o = 0; o < num_ports; o++)
         begin
            gnt_col[i][o] = gnt_matrix[o][i];
            served[i]     = served[i] | (gnt_matrix[o][i] & req_matrix[o][i]);
         end
      end
   end

   assign pop = served & ~empty;

   //////////////////////////////
   // Checks
   //////////////////////////////
   for (genvar i = 0; i < num_ports; i++)
   begin : g_chk
      a_one_output: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt_col[i]));
   end

endmodule

// File: hdl/crossbar.sv
`timescale 1ns/1ps

module crossbar import router_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [num_ports-1:0] gnt_matrix [num_ports],
   input  logic [num_ports-1:0] pop,
   input  flit_t                head [num_ports],
   output logic [num_ports-1:0] out_valid,
   output flit_t                out_flit [num_ports]
);

   flit_t                sel_flit [num_ports];
   logic [num_ports-1:0] sel_valid;

   // Grant-selected mux per output
   always_comb
   begin
      for (int o = 0; o < num_ports; o++)
      begin
         sel_flit[o]  = '0;
         sel_valid[o] = |(gnt_matrix[o] & pop);
         for (int i = 0; i < num_ports; i++)
         begin
            if (gnt_matrix[o][i])
               sel_flit[o] = head[i];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= '0;
      else
         out_valid <= sel_valid;
   end

   always_ff @(posedge clk)
   begin
      for (int o = 0; o < num_ports; o++)
      begin
         if (sel_valid[o])
            out_flit[o] <= sel_flit[o];
      end
   end

endmodule

// File: hdl/router_top.sv
`timescale 1ns/1ps

module router_top import router_pkg::*;
#(
   parameter int unsigned router_x   = 0,
   parameter int unsigned router_y   = 0,
   parameter int          fifo_depth = 4
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [num_ports-1:0] in_valid,
   input  flit_t                in_flit [num_ports],
   output logic [num_ports-1:0] in_full,
   output logic [num_ports-1:0] out_valid,
   output flit_t                out_flit [num_ports]
);

   flit_t                head [num_ports];
   logic [num_ports-1:0] empty;
   logic [num_ports-1:0] pop;
   // Row per input, then transposed to a row per output
   logic [num_ports-1:0] req_row [num_ports];
   logic [num_ports-1:0] req_matrix [num_ports];
   logic [num_ports-1:0] gnt_matrix [num_ports];

   //////////////////////////////
   // Input side
   //////////////////////////////
   for (genvar i = 0; i < num_ports; i++)
   begin : g_port
      input_buffer #(
         .fifo_depth (fifo_depth)
      ) u_input_buffer (
         .clk     (clk),
         .rst     (rst),
         .wr_en   (in_valid[i]),
         .wr_flit (in_flit[i]),
         .pop     (pop[i]),
         .head    (head[i]),
         .empty   (empty[i]),
         .full    (in_full[i])
      );

      route_compute #(
         .router_x (router_x),
         .router_y (router_y)
      ) u_route_compute (
         .clk   (clk),
         .rst   (rst),
         .head  (head[i]),
         .empty (empty[i]),
         .pop   (pop[i]),
         .req   (req_row[i])
      );

      for (genvar o = 0; o < num_ports; o++)
      begin : g_xpose
         assign req_matrix[o][i] = req_row[i][o];
      end
   end

   //////////////////////////////
   // Switching
   //////////////////////////////
   router_ctrl u_router_ctrl (
      .clk        (clk),
      .rst        (rst),
      .req_matrix (req_matrix),
      .empty      (empty),
      .gnt_matrix (gnt_matrix),
      .pop        (pop)
   );

   crossbar u_crossbar (
      .clk        (clk),
      .rst        (rst),
      .gnt_matrix (gnt_matrix),
      .pop        (pop),
      .head       (head),
      .out_valid  (out_valid),
      .out_flit   (out_flit)
   );

endmodule

// File: bench/router_checker.sv
`timescale 1ns/1ps

module router_checker import router_pkg::*;
#(
   parameter int queue_depth = 64,
   parameter int fifo_depth  = 4
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [num_ports-1:0] in_valid,
   input  logic [num_ports-1:0] in_full,
   input  logic [num_ports-1:0] out_valid,
   input  flit_t                out_flit [num_ports],
   output int                   mismatches,
   output int                   strays,
   output int                   full_errors,
   output int                   checked
);

   // Expected flits per output, in the order they must leave
   flit_t exp_mem [num_ports][queue_depth];
   int    exp_src [num_ports][queue_depth];
   int    wr_idx  [num_ports] = '{default: 0};
   int    rd_idx  [num_ports] = '{default: 0};
   // Modelled FIFO occupancy per input
   int    fill    [num_ports];

   task automatic push_expected(input int port, input int src, input flit_t f);
      exp_mem[port][wr_idx[port]] = f;
      exp_src[port][wr_idx[port]] = src;
      wr_idx[port]++;
   endtask

   //////////////////////////////
   // Output monitor
   //////////////////////////////
   always @(posedge clk)
   begin
      if (rst)
      begin
         mismatches  = 0;
         strays      = 0;
         full_errors = 0;
         checked     = 0;
         for (int i = 0; i < num_ports; i++)
            fill[i] = 0;
      end
      else
      begin
         for (int o = 0; o < num_ports; o++)
         begin
            if (out_valid[o])
            begin
               if (rd_idx[o] == wr_idx[o])
               begin
                  strays++;
                  $display("Unexpected flit %h left output %0d at %0t, none was due there",
                           out_flit[o], o, $time);
               end
               else
               begin
                  // Order, integrity and wormhole contiguity in one compare
                  if (out_flit[o] !== exp_mem[o][rd_idx[o]])
                  begin
                     mismatches++;
                     $display("FAILED at %0t: output %0d flit %0d is %h, expected %h",
                              $time, o, rd_idx[o], out_flit[o], exp_mem[o][rd_idx[o]]);
                  end
                  // Its pop took place one edge ago
                  fill[exp_src[o][rd_idx[o]]]--;
                  rd_idx[o]++;
                  checked++;
               end
            end
         end

         // Full level against the occupancy left by the last edge
         for (int i = 0; i < num_ports; i++)
         begin
            if (in_full[i] !== (fill[i] == fifo_depth))
            begin
               full_errors++;
               $display("FAILED at %0t: in_full of input %0d is %b, expected %b",
                        $time, i, in_full[i], fill[i] == fifo_depth);
            end
            if (in_valid[i])
               fill[i]++;
         end
      end
   end

endmodule

// File: bench/router_tb.sv
`timescale 1ns/1ps

module router_tb import router_pkg::*;
();

   localparam int node_x    = 2;
   localparam int node_y    = 2;
   localparam int depth     = 4;
   localparam int num_rows  = 13;
   localparam int max_flits = 64;
   localparam int col_port  = 0;
   localparam int col_dx    = 1;
   localparam int col_dy    = 2;
   localparam int col_len   = 3;
   localparam int col_start = 4;

   // Input port, dest x, dest y, flits, start cycle
   localparam int stim [num_rows][5] = '{
      '{0, 4, 1, 3, 0},  '{1, 0, 3, 2, 2},  '{2, 2, 4, 4, 4},
      '{3, 2, 0, 3, 6},  '{4, 2, 2, 1, 8},
      // Same cycle on east, input 1 goes first
      '{1, 5, 2, 4, 30}, '{3, 3, 0, 3, 30},
      // West, the earlier head wins over the lower input
      '{2, 1, 3, 5, 50}, '{0, 0, 4, 3, 51},
      // North held by input 0 while input 3 fills its FIFO
      '{0, 2, 4, 10, 90}, '{3, 2, 6, 8, 91}, '{2, 0, 2, 6, 90}, '{4, 4, 2, 6, 90}
   };

   logic                 clk;
   logic                 rst;
   logic [num_ports-1:0] in_valid;
   flit_t                in_flit [num_ports];
   logic [num_ports-1:0] in_full;
   logic [num_ports-1:0] out_valid;
   flit_t                out_flit [num_ports];
   int                   mismatches;
   int                   strays;
   int                   full_errors;
   int                   checked;
   flit_t                flits [max_flits];
   int                   base [num_rows];
   int                   total_flits;
   logic [31:0]          rng_state;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      return s ^ (s << 5);
   endfunction

   // Dimension order, x first
   function automatic int xy_output(input int dx, input int dy);
      if (dx > node_x)
         return port_east;
      if (dx < node_x)
         return port_west;
      if (dy > node_y)
         return port_north;
      if (dy < node_y)
         return port_south;
      return port_local;
   endfunction

   function automatic int find_row(input int port, input int from);
      for (int r = from; r < num_rows; r++)
         if (stim[r][col_port] == port)
            return r;
      return num_rows;
   endfunction

   task automatic build_flits();
      int    pos;
      int    len;
      flit_t f;
      pos = 0;
      for (int r = 0; r < num_rows; r++)
      begin
         len     = stim[r][col_len];
         base[r] = pos;
         for (int k = 0; k < len; k++)
         begin
            rng_state = xorshift(rng_state);
            f = '0;
            if (k == 0)
            begin
               f.hd.kind    = (len == 1) ? kind_single : kind_head;
               f.hd.dest_x  = coord_width'(stim[r][col_dx]);
               f.hd.dest_y  = coord_width'(stim[r][col_dy]);
               f.hd.payload = rng_state[7:0];
            end
            else
            begin
               f.bd.kind = (k == len - 1) ? kind_tail : kind_body;
               f.bd.data = rng_state[13:0];
            end
            flits[pos] = f;
            u_checker.push_expected(xy_output(stim[r][col_dx], stim[r][col_dy]),
                                    stim[r][col_port], f);
            pos++;
         end
      end
      total_flits = pos;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   router_top #(
      .router_x   (node_x),
      .router_y   (node_y),
      .fifo_depth (depth)
   ) u_router_top (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .in_full   (in_full),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

   router_checker #(
      .fifo_depth (depth)
   ) u_checker (
      .clk         (clk),
      .rst         (rst),
      .in_valid    (in_valid),
      .in_full     (in_full),
      .out_valid   (out_valid),
      .out_flit    (out_flit),
      .mismatches  (mismatches),
      .strays      (strays),
      .full_errors (full_errors),
      .checked     (checked)
   );

   //////////////////////////////
   // Driver
   //////////////////////////////
   initial
   begin
      int cur_row [num_ports];
      int cur_k [num_ports];
      int row_ptr [num_ports];
      int rows_left;
      int drive_cycle;
      int nxt;
      rst       = 1'b1;
      in_valid  = '0;
      rng_state = 32'd34731;
      for (int p = 0; p < num_ports; p++)
      begin
         in_flit[p] = '0;
         cur_row[p] = -1;
         cur_k[p]   = 0;
         row_ptr[p] = 0;
      end
      build_flits();
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      rows_left   = num_rows;
      drive_cycle = 0;
      while (rows_left > 0)
      begin
         @(posedge clk);
         for (int p = 0; p < num_ports; p++)
         begin
            if (cur_row[p] < 0)
            begin
               nxt = find_row(p, row_ptr[p]);
               if (nxt < num_rows && stim[nxt][col_start] <= drive_cycle)
               begin
                  cur_row[p] = nxt;
                  cur_k[p]   = 0;
                  row_ptr[p] = nxt + 1;
               end
            end
            // One flit in flight at most, so a low in_full still holds next edge
            if (cur_row[p] >= 0 && !in_full[p] && !in_valid[p])
            begin
               in_valid[p] <= 1'b1;
               in_flit[p]  <= flits[base[cur_row[p]] + cur_k[p]];
               cur_k[p]++;
               if (cur_k[p] == stim[cur_row[p]][col_len])
               begin
                  cur_row[p] = -1;
                  rows_left--;
               end
            end
            else
               in_valid[p] <= 1'b0;
         end
         drive_cycle++;
      end
      @(posedge clk);
      in_valid <= '0;
      while (checked < total_flits)
         @(posedge clk);
      repeat (10) @(posedge clk);
      $display("Errors: %0d mismatched, %0d unexpected, %0d in_full, %0d missing",
               mismatches, strays, full_errors, total_flits - checked);
      if (mismatches == 0 && strays == 0 && full_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   // Twenty cycles per flit plus slack
   initial
   begin
      int cycle_count;
      int cycle_limit;
      @(negedge rst);
      cycle_count = 0;
      cycle_limit = 20 * total_flits + 200;
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: run stopped after %0d cycles with %0d of %0d flits received",
               cycle_count, checked, total_flits);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: sources.f
hdl/router_pkg.sv
hdl/input_buffer.sv
hdl/route_compute.sv
hdl/output_arbiter.sv
hdl/router_ctrl.sv
hdl/crossbar.sv
hdl/router_top.sv
bench/router_checker.sv
bench/router_tb.sv

// File: Bender.yml
package:
  name: mesh_router

sources:
  - files:
      - hdl/router_pkg.sv
      - hdl/input_buffer.sv
      - hdl/route_compute.sv
      - hdl/output_arbiter.sv
      - hdl/router_ctrl.sv
      - hdl/crossbar.sv
      - hdl/router_top.sv
  - target: test
    files:
      - bench/router_checker.sv
      - bench/router_tb.sv
